//--- sources.f
+incdir+verif
src/elevator_view_pkg.sv
src/scan_region_decode.sv
src/car_shaft_render.sv
src/pixel_color_out.sv
src/pixel_gen.sv
verif/tb_clock_gen.sv
verif/pixel_gen_tb.sv

//--- Makefile
TOP := pixel_gen_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard src/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module pixel_gen

clean:
	rm -rf obj_dir

//--- verif/pixel_gen_model.svh
`ifndef PIXEL_GEN_MODEL_SVH
`define PIXEL_GEN_MODEL_SVH

// LCG step, Numerical Recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Expected colour of one pixel from the screen rules
function automatic elevator_view_pkg::rgb_t expected_rgb(
    input logic                            en,
    input logic [7:0]                      dest,
    input elevator_view_pkg::sim_code_t    code,
    input elevator_view_pkg::pixel_coord_t x_in,
    input elevator_view_pkg::pixel_coord_t y_in
);
    int x;
    int y;
    int ground;
    int side_r;
    int band;
    int level;
    int top;
    bit right_shaft;
    x      = int'(x_in);
    y      = int'(y_in);
    ground = int'(elevator_view_pkg::SCREEN_H) - int'(elevator_view_pkg::TOP_MARGIN);
    side_r = int'(elevator_view_pkg::SCREEN_W) - int'(elevator_view_pkg::SIDE_MARGIN);
    if (!en) begin
        return elevator_view_pkg::COL_BLACK;
    end
    if (x < int'(elevator_view_pkg::SIDE_MARGIN)
        || (x >= side_r && x < int'(elevator_view_pkg::SCREEN_W) && y < ground)
        || y < int'(elevator_view_pkg::TOP_MARGIN)) begin
        return elevator_view_pkg::COL_SKY;
    end
    if ((x >= int'(elevator_view_pkg::SIDE_MARGIN) && x < int'(elevator_view_pkg::LEFT_FACADE_END))
        || (x >= int'(elevator_view_pkg::OUTLINE_R_END) && x < side_r)) begin
        band = (y - int'(elevator_view_pkg::TOP_MARGIN)) / int'(elevator_view_pkg::FLOOR_H);
        if (band > 5) begin
            band = 5;
        end
        return (band % 2 == 1) ? elevator_view_pkg::COL_BAND_LIGHT
                               : elevator_view_pkg::COL_BAND_DARK;
    end
    if (y >= ground) begin
        return elevator_view_pkg::COL_GRASS;
    end
    if ((x >= int'(elevator_view_pkg::SHAFT_L_END) && x < int'(elevator_view_pkg::OUTLINE_M_END))
        || (x >= int'(elevator_view_pkg::SHAFT_R_END) && x < int'(elevator_view_pkg::OUTLINE_R_END))) begin
        return elevator_view_pkg::COL_BLACK;
    end
    if (x < int'(elevator_view_pkg::LEFT_FACADE_END) || x >= int'(elevator_view_pkg::SHAFT_R_END)) begin
        return elevator_view_pkg::COL_GRASS;
    end

    right_shaft = x >= int'(elevator_view_pkg::OUTLINE_M_END);
    level = right_shaft ? int'(dest[3:0]) : int'(dest[7:4]);
    if (level > int'(elevator_view_pkg::TOP_LEVEL)) begin
        level = int'(elevator_view_pkg::TOP_LEVEL);
    end
    top = ground - int'(elevator_view_pkg::FLOOR_H) - (level * int'(elevator_view_pkg::FLOOR_H)) / 2;
    if (code == 2'd0) begin
        return (y >= ground - int'(elevator_view_pkg::CAR_H_IDLE)) ? elevator_view_pkg::COL_CAR
                                                                   : elevator_view_pkg::COL_SHAFT;
    end
    if (code == 2'd1) begin
        return (y >= top && y < top + int'(elevator_view_pkg::FLOOR_H)) ? elevator_view_pkg::COL_CAR
                                                                        : elevator_view_pkg::COL_SHAFT;
    end
    if (right_shaft && x < int'(elevator_view_pkg::STOP_X_END)
        && y >= int'(elevator_view_pkg::STOP_Y_BEGIN) && y < int'(elevator_view_pkg::STOP_Y_END)) begin
        return elevator_view_pkg::COL_STOP;
    end
    return elevator_view_pkg::COL_BLACK;
endfunction

`endif

//--- verif/pixel_gen_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_gen_tb;

    localparam int CYCLE_LIMIT = 40000;

    logic                            clk;
    logic                            rst_n;
    logic                            enable;
    logic [7:0]                      destination;
    elevator_view_pkg::sim_code_t    sim_state;
    elevator_view_pkg::pixel_coord_t x_coord;
    elevator_view_pkg::pixel_coord_t y_coord;
    elevator_view_pkg::rgb_t         rgb;

    logic [31:0]             rand_state = 32'h2da3e6f5;
    elevator_view_pkg::rgb_t exp_pipe [2];
    int                      pipe_fill = 0;
    int                      cycle_count = 0;

    `include "pixel_gen_model.svh"

    tb_clock_gen clock_gen_i (
        .clk (clk)
    );

    pixel_gen pixel_gen_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .destination (destination),
        .sim_state   (sim_state),
        .x_coord     (x_coord),
        .y_coord     (y_coord),
        .rgb         (rgb)
    );

    function automatic logic [31:0] draw_random();
        rand_state = lcg_next(rand_state);
        return rand_state;
    endfunction

    task automatic check_value(input string name, input logic [11:0] actual,
                               input logic [11:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_pixel(input logic en, input logic [7:0] dest,
                               input elevator_view_pkg::sim_code_t code,
                               input elevator_view_pkg::pixel_coord_t x,
                               input elevator_view_pkg::pixel_coord_t y);
        @(posedge clk);
        enable      <= en;
        destination <= dest;
        sim_state   <= code;
        x_coord     <= x;
        y_coord     <= y;
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("** FAIL **");
            $fatal(1, "Timeout, sweeps still running after %0d cycles", CYCLE_LIMIT);
        end
    endtask

    task automatic sweep_column(input elevator_view_pkg::sim_code_t code, input logic [7:0] dest,
                                input elevator_view_pkg::pixel_coord_t x);
        for (int y = 0; y < int'(elevator_view_pkg::SCREEN_H); y++) begin
            drive_pixel(1'b1, dest, code, x, elevator_view_pkg::pixel_coord_t'(y));
        end
    endtask

    // Shaft area keeps x near the shafts and y on screen, else anything goes
    task automatic drive_random_pixel(input bit shaft_area);
        logic [31:0]                     r_pos;
        logic [31:0]                     r_ctl;
        elevator_view_pkg::pixel_coord_t x;
        elevator_view_pkg::pixel_coord_t y;
        r_pos = draw_random();
        r_ctl = draw_random();
        if (shaft_area) begin
            x = elevator_view_pkg::pixel_coord_t'(200 + int'(r_pos[31:16]) % 216);
            y = elevator_view_pkg::pixel_coord_t'(int'(r_pos[15:6]) % 480);
        end else begin
            x = r_pos[31:22];
            y = r_pos[21:12];
        end
        drive_pixel(shaft_area || r_ctl[31:29] != 3'd0, r_ctl[27:20], r_ctl[17:16], x, y);
    endtask

    // Two-deep line of expected colours, matching the DUT latency
    always @(posedge clk) begin
        if (pipe_fill == 2) begin
            check_value("rgb", rgb, exp_pipe[1]);
        end
        exp_pipe[1] = exp_pipe[0];
        if (!rst_n) begin
            exp_pipe[0] = elevator_view_pkg::COL_BLACK;
        end else begin
            exp_pipe[0] = expected_rgb(enable, destination, sim_state, x_coord, y_coord);
        end
        if (pipe_fill < 2) begin
            pipe_fill = pipe_fill + 1;
        end
    end

    initial begin
        logic [3:0] lvl;
        rst_n       = 1'b0;
        enable      = 1'b0;
        destination = 8'h00;
        sim_state   = 2'd0;
        x_coord     = '0;
        y_coord     = '0;

        for (int i = 0; i < 4; i++) begin
            drive_pixel(1'b0, 8'h00, 2'd0, '0, '0);
        end
        rst_n <= 1'b1;
        for (int i = 0; i < 2; i++) begin
            drive_pixel(1'b0, 8'hff, 2'd1, 10'd250, 10'd400);
        end

        // Static scene, all codes, coordinates past the screen edge too
        for (int i = 0; i < 3000; i++) begin
            drive_random_pixel(1'b0);
        end

        sweep_column(2'd0, 8'h5a, 10'd250);
        sweep_column(2'd0, 8'h5a, 10'd350);

        // Left and right nibbles each walk all 16 levels
        for (int i = 0; i < 16; i++) begin
            lvl = 4'(i);
            sweep_column(2'd1, {lvl, ~lvl}, 10'd250);
            sweep_column(2'd1, {lvl, ~lvl}, 10'd350);
        end

        for (int c = 2; c < 4; c++) begin
            sweep_column(2'(c), 8'h37, 10'd250);
            sweep_column(2'(c), 8'h37, 10'd305);
            sweep_column(2'(c), 8'h37, 10'd339);
            sweep_column(2'(c), 8'h37, 10'd340);
        end

        // Codes and levels change on every pixel
        for (int i = 0; i < 2000; i++) begin
            drive_random_pixel(1'b1);
        end

        for (int i = 0; i < 4; i++) begin
            drive_pixel(1'b0, 8'h00, 2'd0, '0, '0);
        end
        @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- src/pixel_gen.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_gen (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          enable,
    input  wire logic [7:0]                    destination,
    input  wire elevator_view_pkg::sim_code_t  sim_state,
    input  wire elevator_view_pkg::pixel_coord_t x_coord,
    input  wire elevator_view_pkg::pixel_coord_t y_coord,
    output elevator_view_pkg::rgb_t            rgb
);

    elevator_view_pkg::scan_info_t scan;
    elevator_view_pkg::rgb_t       shaft_rgb_l;
    elevator_view_pkg::rgb_t       shaft_rgb_r;

    // Stage 1, coordinates to region
    scan_region_decode decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .destination (destination),
        .sim_state   (sim_state),
        .x_coord     (x_coord),
        .y_coord     (y_coord),
        .scan        (scan)
    );

    // Left shaft follows the upper nibble
    car_shaft_render shaft_l_i (
        .scan      (scan),
        .use_upper (1'b1),
        .shaft_rgb (shaft_rgb_l)
    );

    car_shaft_render shaft_r_i (
        .scan      (scan),
        .use_upper (1'b0),
        .shaft_rgb (shaft_rgb_r)
    );

    // Stage 2, colour select and output register
    pixel_color_out color_out_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .scan        (scan),
        .shaft_rgb_l (shaft_rgb_l),
        .shaft_rgb_r (shaft_rgb_r),
        .rgb         (rgb)
    );

endmodule

`default_nettype wire

//--- src/pixel_color_out.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_color_out (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire elevator_view_pkg::scan_info_t scan,
    input  wire elevator_view_pkg::rgb_t       shaft_rgb_l,
    input  wire elevator_view_pkg::rgb_t       shaft_rgb_r,
    output elevator_view_pkg::rgb_t            rgb
);

    elevator_view_pkg::rgb_t rgb_next;
    elevator_view_pkg::rgb_t band_rgb;

    // Floor bands alternate from the top, darkest first
    always_comb begin
        if (scan.band[0]) begin
            band_rgb = elevator_view_pkg::COL_BAND_LIGHT;
        end else begin
            band_rgb = elevator_view_pkg::COL_BAND_DARK;
        end
    end

    always_comb begin
        case (scan.region)
            elevator_view_pkg::REG_BLANK: begin
                rgb_next = elevator_view_pkg::COL_BLACK;
            end
            elevator_view_pkg::REG_SKY: begin
                rgb_next = elevator_view_pkg::COL_SKY;
            end
            elevator_view_pkg::REG_FACADE: begin
                rgb_next = band_rgb;
            end
            elevator_view_pkg::REG_OUTLINE: begin
                rgb_next = elevator_view_pkg::COL_BLACK;
            end
            elevator_view_pkg::REG_SHAFT_L: begin
                rgb_next = shaft_rgb_l;
            end
            elevator_view_pkg::REG_SHAFT_R: begin
                rgb_next = shaft_rgb_r;
            end
            elevator_view_pkg::REG_GRASS: begin
                rgb_next = elevator_view_pkg::COL_GRASS;
            end
            default: begin
                rgb_next = elevator_view_pkg::COL_BLACK;
            end
        endcase
    end

    // Output register, black while in reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= elevator_view_pkg::COL_BLACK;
        end else begin
            rgb <= rgb_next;
        end
    end

    a_blank_is_black: assert property (@(posedge clk) disable iff (!rst_n)
        scan.region == elevator_view_pkg::REG_BLANK |=> rgb == elevator_view_pkg::COL_BLACK)
        else $error("color out: blank pixel not black, got %h", rgb);

endmodule

`default_nettype wire

//--- src/car_shaft_render.sv
`timescale 1ns/10ps
`default_nettype none

module car_shaft_render (
    input  wire elevator_view_pkg::scan_info_t scan,
    input  wire logic                          use_upper,
    output elevator_view_pkg::rgb_t            shaft_rgb
);

    elevator_view_pkg::level_t       level_sel;
    elevator_view_pkg::level_t       level_clamped;
    elevator_view_pkg::pixel_coord_t lift;
    elevator_view_pkg::pixel_coord_t car_top;
    logic                            in_car;
    logic                            in_idle_car;

    // Car position from the destination level
    always_comb begin
        level_sel = use_upper ? scan.level_l : scan.level_r;
        if (level_sel > elevator_view_pkg::TOP_LEVEL) begin
            level_clamped = elevator_view_pkg::TOP_LEVEL;
        end else begin
            level_clamped = level_sel;
        end

        // Half a floor per level step, rounded down
        lift    = (elevator_view_pkg::pixel_coord_t'(level_clamped)
                   * elevator_view_pkg::FLOOR_H) >> 1;
        car_top = elevator_view_pkg::CAR_TOP_BASE - lift;

        in_car      = scan.y >= car_top
                   && scan.y < car_top + elevator_view_pkg::FLOOR_H;
        in_idle_car = scan.y >= elevator_view_pkg::IDLE_CAR_TOP;
    end

    always_comb begin
        case (scan.state)
            elevator_view_pkg::SIM_IDLE: begin
                shaft_rgb = in_idle_car ? elevator_view_pkg::COL_CAR
                                        : elevator_view_pkg::COL_SHAFT;
            end
            elevator_view_pkg::SIM_MOVING: begin
                shaft_rgb = in_car ? elevator_view_pkg::COL_CAR
                                   : elevator_view_pkg::COL_SHAFT;
            end
            default: begin
                // Stopped shaft goes dark, sign only where decode flagged it
                shaft_rgb = scan.stop_sign ? elevator_view_pkg::COL_STOP
                                           : elevator_view_pkg::COL_BLACK;
            end
        endcase
    end

    // Top level must land on the first facade row
    always_comb begin
        assert (car_top >= elevator_view_pkg::TOP_MARGIN
                && car_top <= elevator_view_pkg::CAR_TOP_BASE)
        else $error("render: car top %0d outside shaft", car_top);
    end

endmodule

`default_nettype wire

//--- src/scan_region_decode.sv
`timescale 1ns/10ps
`default_nettype none

module scan_region_decode (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            enable,
    input  wire logic [7:0]                      destination,
    input  wire elevator_view_pkg::sim_code_t    sim_state,
    input  wire elevator_view_pkg::pixel_coord_t x_coord,
    input  wire elevator_view_pkg::pixel_coord_t y_coord,
    output elevator_view_pkg::scan_info_t        scan
);

    logic                             in_sky;
    logic                             in_facade;
    logic                             in_outline;
    logic                             in_shaft_l;
    logic                             in_shaft_r;
    logic                             above_ground;
    elevator_view_pkg::pixel_coord_t  y_off;
    elevator_view_pkg::pixel_coord_t  band_raw;
    elevator_view_pkg::scan_info_t    scan_next;

    always_comb begin
        above_ground = y_coord < elevator_view_pkg::GROUND_Y;
        in_sky = (x_coord < elevator_view_pkg::SIDE_MARGIN)
              || (x_coord >= elevator_view_pkg::SCREEN_W - elevator_view_pkg::SIDE_MARGIN
                  && x_coord < elevator_view_pkg::SCREEN_W && above_ground)
              || (y_coord < elevator_view_pkg::TOP_MARGIN);
        in_facade = (x_coord >= elevator_view_pkg::SIDE_MARGIN
                     && x_coord < elevator_view_pkg::LEFT_FACADE_END)
                 || (x_coord >= elevator_view_pkg::OUTLINE_R_END
                     && x_coord < elevator_view_pkg::SCREEN_W - elevator_view_pkg::SIDE_MARGIN);
        in_outline = (x_coord >= elevator_view_pkg::SHAFT_L_END
                      && x_coord < elevator_view_pkg::OUTLINE_M_END)
                  || (x_coord >= elevator_view_pkg::SHAFT_R_END
                      && x_coord < elevator_view_pkg::OUTLINE_R_END);
        in_shaft_l = x_coord >= elevator_view_pkg::LEFT_FACADE_END
                  && x_coord < elevator_view_pkg::SHAFT_L_END;
        in_shaft_r = x_coord >= elevator_view_pkg::OUTLINE_M_END
                  && x_coord < elevator_view_pkg::SHAFT_R_END;

        // Only used on facade rows, which are never above the top margin
        y_off    = y_coord - elevator_view_pkg::TOP_MARGIN;
        band_raw = y_off / elevator_view_pkg::FLOOR_H;

        scan_next.y       = y_coord;
        scan_next.level_l = destination[7:4];
        scan_next.level_r = destination[3:0];
        if (band_raw > elevator_view_pkg::pixel_coord_t'(elevator_view_pkg::TOP_BAND)) begin
            scan_next.band = elevator_view_pkg::TOP_BAND;
        end else begin
            scan_next.band = band_raw[2:0];
        end

        case (sim_state)
            2'd0:    scan_next.state = elevator_view_pkg::SIM_IDLE;
            2'd1:    scan_next.state = elevator_view_pkg::SIM_MOVING;
            default: scan_next.state = elevator_view_pkg::SIM_STOP;
        endcase

        if (!enable) begin
            scan_next.region = elevator_view_pkg::REG_BLANK;
        end else if (in_sky) begin
            scan_next.region = elevator_view_pkg::REG_SKY;
        end else if (in_facade) begin
            scan_next.region = elevator_view_pkg::REG_FACADE;
        end else if (above_ground && in_outline) begin
            scan_next.region = elevator_view_pkg::REG_OUTLINE;
        end else if (above_ground && in_shaft_l) begin
            scan_next.region = elevator_view_pkg::REG_SHAFT_L;
        end else if (above_ground && in_shaft_r) begin
            scan_next.region = elevator_view_pkg::REG_SHAFT_R;
        end else begin
            scan_next.region = elevator_view_pkg::REG_GRASS;
        end

        // Red sign box sits in the right shaft only
        scan_next.stop_sign = scan_next.region == elevator_view_pkg::REG_SHAFT_R
                           && scan_next.state == elevator_view_pkg::SIM_STOP
                           && x_coord < elevator_view_pkg::STOP_X_END
                           && y_coord >= elevator_view_pkg::STOP_Y_BEGIN
                           && y_coord < elevator_view_pkg::STOP_Y_END;
    end

    always_ff @(posedge clk) begin
        scan <= scan_next;
        if (!rst_n) begin
            scan.region    <= elevator_view_pkg::REG_BLANK;
            scan.state     <= elevator_view_pkg::SIM_IDLE;
            scan.stop_sign <= 1'b0;
        end
    end

    a_blank_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |=> scan.region == elevator_view_pkg::REG_BLANK)
        else $error("decode: disabled pixel not blank");

    a_band_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        scan.band <= elevator_view_pkg::TOP_BAND)
        else $error("decode: band %0d out of range", scan.band);

endmodule

`default_nettype wire

//--- src/elevator_view_pkg.sv
`default_nettype none

package elevator_view_pkg;

    typedef logic [9:0] pixel_coord_t;
    typedef logic [3:0] level_t;
    typedef logic [3:0] color_chan_t;
    typedef logic [1:0] sim_code_t;
    typedef logic [2:0] floor_band_t;

    typedef struct packed {
        color_chan_t r;
        color_chan_t g;
        color_chan_t b;
    } rgb_t;

    typedef enum logic [1:0] {
        SIM_IDLE   = 2'd0,
        SIM_MOVING = 2'd1,
        SIM_STOP   = 2'd2
    } sim_state_t;

    typedef enum logic [2:0] {
        REG_BLANK   = 3'd0,
        REG_SKY     = 3'd1,
        REG_FACADE  = 3'd2,
        REG_OUTLINE = 3'd3,
        REG_SHAFT_L = 3'd4,
        REG_SHAFT_R = 3'd5,
        REG_GRASS   = 3'd6
    } region_t;

    // Per-pixel record between decode and the later stages
    typedef struct packed {
        region_t      region;
        pixel_coord_t y;
        floor_band_t  band;
        sim_state_t   state;
        level_t       level_l;
        level_t       level_r;
        logic         stop_sign;
    } scan_info_t;

    // Screen geometry
    localparam pixel_coord_t SCREEN_W        = 10'd640;
    localparam pixel_coord_t SCREEN_H        = 10'd480;
    localparam pixel_coord_t SIDE_MARGIN     = 10'd20;
    localparam pixel_coord_t TOP_MARGIN      = 10'd15;
    localparam pixel_coord_t FLOOR_H         = 10'd75;
    localparam pixel_coord_t CAR_H_IDLE      = 10'd70;
    localparam pixel_coord_t LEFT_FACADE_END = 10'd210;
    localparam pixel_coord_t SHAFT_L_END     = 10'd295;
    localparam pixel_coord_t OUTLINE_M_END   = 10'd305;
    localparam pixel_coord_t SHAFT_R_END     = 10'd395;
    localparam pixel_coord_t OUTLINE_R_END   = 10'd405;
    localparam pixel_coord_t STOP_X_END      = 10'd340;
    localparam pixel_coord_t STOP_Y_BEGIN    = 10'd200;
    localparam pixel_coord_t STOP_Y_END      = 10'd260;
    localparam level_t       TOP_LEVEL       = 4'd10;
    localparam floor_band_t  TOP_BAND        = 3'd5;

    // First grass row, and car top rows derived from it
    localparam pixel_coord_t GROUND_Y     = SCREEN_H - TOP_MARGIN;
    localparam pixel_coord_t CAR_TOP_BASE = GROUND_Y - FLOOR_H;
    localparam pixel_coord_t IDLE_CAR_TOP = GROUND_Y - CAR_H_IDLE;

    localparam rgb_t COL_SKY        = '{r: 4'd2,  g: 4'd8,  b: 4'd15};
    localparam rgb_t COL_BAND_DARK  = '{r: 4'd9,  g: 4'd10, b: 4'd10};
    localparam rgb_t COL_BAND_LIGHT = '{r: 4'd11, g: 4'd11, b: 4'd11};
    localparam rgb_t COL_BLACK      = '{r: 4'd0,  g: 4'd0,  b: 4'd0};
    localparam rgb_t COL_SHAFT      = '{r: 4'd8,  g: 4'd4,  b: 4'd1};
    localparam rgb_t COL_CAR        = '{r: 4'd4,  g: 4'd4,  b: 4'd4};
    localparam rgb_t COL_STOP       = '{r: 4'd15, g: 4'd0,  b: 4'd0};
    localparam rgb_t COL_GRASS      = '{r: 4'd0,  g: 4'd15, b: 4'd0};

endpackage

`default_nettype wire
